/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  localparam int XLEN     = 32;
  localparam int REG_ID_W = 5;

  // major opcodes of the classes this front end handles
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // funct3 for OP / OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra, picked by bit 30
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 access width for LOAD / STORE, bit 2 is the unsigned flag
  localparam logic [2:0] F3_BYTE = 3'b000;
  localparam logic [2:0] F3_HALF = 3'b001;
  localparam logic [2:0] F3_WORD = 3'b010;

  typedef enum logic [3:0] {
    ALU_NOP = 4'd0,
    ALU_AND = 4'd1,
    ALU_OR  = 4'd2,
    ALU_XOR = 4'd3,
    ALU_ADD = 4'd4,
    ALU_SUB = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SRA = 4'd7,
    ALU_SLL = 4'd8,
    ALU_LT  = 4'd9,
    ALU_LTU = 4'd10,
    ALU_EQ  = 4'd11,
    ALU_NE  = 4'd12,
    ALU_GE  = 4'd13,
    ALU_GEU = 4'd14
  } alu_op_e;

  typedef enum logic [1:0] {
    LEN_BYTE = 2'd0,
    LEN_HALF = 2'd1,
    LEN_WORD = 2'd3  // byte count minus one
  } lsb_len_e;

  typedef enum logic [1:0] {
    ROB_REG   = 2'b00,
    ROB_STORE = 2'b01
  } rob_kind_e;

endpackage

`default_nettype wire

/* hw/issue_pkg.sv */
`default_nettype none

package issue_pkg;
  import isa_pkg::*;

  localparam int TAG_W = 4;  // reorder-buffer tag

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic [XLEN-1:0]  value;
    logic             valid;
    logic [TAG_W-1:0] tag;  // producer tag when valid is low
  } rf_resp_t;

  typedef struct packed {
    logic [XLEN-1:0]  value;
    logic             valid;
    logic [TAG_W-1:0] tag;
  } operand_t;

  typedef enum logic [1:0] {
    CLS_RESULT = 2'd0,  // value known at decode, rob only
    CLS_ALU    = 2'd1,
    CLS_MEM    = 2'd2
  } instr_class_e;

  typedef struct packed {
    instr_class_e         cls;
    alu_op_e              alu_op;
    logic [XLEN-1:0]      imm;
    logic                 use_imm;
    logic                 is_store;
    logic                 is_signed;
    lsb_len_e             len;
    logic [REG_ID_W-1:0]  rs1;
    logic [REG_ID_W-1:0]  rs2;
    logic [REG_ID_W-1:0]  rd;
    logic                 res_ready;
    logic [XLEN-1:0]      res_value;
    logic                 is_jump;
  } decoded_t;

  typedef struct packed {
    alu_op_e          op;
    operand_t         rs1;
    operand_t         rs2;
    logic [TAG_W-1:0] rd_tag;
  } rs_pkt_t;

  typedef struct packed {
    logic             is_store;
    logic             is_signed;
    lsb_len_e         len;
    operand_t         addr;
    operand_t         value;
    logic [11:0]      offset;
    logic [TAG_W-1:0] rd_tag;
  } lsb_pkt_t;

  typedef struct packed {
    rob_kind_e           kind;
    logic                ready;
    logic [XLEN-1:0]     value;
    logic [REG_ID_W-1:0] rd;
  } rob_pkt_t;

endpackage

`default_nettype wire

/* hw/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic clk_in,
  input  logic rst_in,
  input  logic imem_ack,
  input  logic rs_full,
  input  logic lsb_full,
  input  logic rob_full,
  output logic imem_req,
  output logic instr_load,
  output logic issue_en,
  output logic pc_advance
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK_LOW,
    ISSUE
  } state_e;

  state_e state, state_nxt;
  logic   stall;

  assign stall = rs_full | lsb_full | rob_full;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:         if (!imem_ack) state_nxt = REQ;  // memory must be idle first
      REQ:          if (imem_ack) state_nxt = WAIT_ACK_LOW;
      WAIT_ACK_LOW: if (!imem_ack) state_nxt = ISSUE;
      ISSUE:        if (!stall) state_nxt = REQ;  // hold the word until buffers free up
      default:      state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign imem_req   = (state == REQ);
  assign instr_load = (state == REQ) & imem_ack;  // data valid while ack is high
  assign issue_en   = (state == ISSUE) & ~stall;
  assign pc_advance = issue_en;

  // four-phase rule: once raised, req holds until memory answers
  a_req_held: assert property (@(posedge clk_in) disable iff (rst_in)
    (imem_req && !imem_ack) |=> imem_req);

endmodule

`default_nettype wire

/* hw/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_counter
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            pc_advance,
  input  decoded_t        dec,
  output logic [XLEN-1:0] pc
);

  logic [XLEN-1:0] pc_next;

  // jal target comes straight from the decoded j-immediate
  assign pc_next = dec.is_jump ? pc + dec.imm : pc + XLEN'(4);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc <= RESET_PC;
    end else if (pc_advance) begin
      pc <= pc_next;
    end
  end

  // fetch addresses must be whole words, including jump targets
  a_pc_aligned: assert property (@(posedge clk_in) disable iff (rst_in)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic            clk_in,
  input  logic            instr_load,
  input  logic [XLEN-1:0] imem_data,
  input  logic [XLEN-1:0] pc,
  output decoded_t        dec
);

  logic [XLEN-1:0] instr_q;
  logic [XLEN-1:0] imm_i, imm_s, imm_u, imm_j;
  logic [2:0]      funct3;

  always_ff @(posedge clk_in) begin
    if (instr_load) instr_q <= imem_data;
  end

  assign funct3 = instr_q[14:12];
  assign imm_i  = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s  = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_u  = {instr_q[31:12], 12'b0};
  assign imm_j  = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

  // alt is bit 30 where it selects sub / sra
  function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    op = ALU_NOP;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_LT;
      F3_SLTU:    op = ALU_LTU;
      F3_XOR:     op = ALU_XOR;
      F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_NOP;
    endcase
    return op;
  endfunction

  function automatic lsb_len_e len_map(input logic [2:0] f3);
    lsb_len_e len;
    case (f3[1:0])
      F3_BYTE[1:0]: len = LEN_BYTE;
      F3_HALF[1:0]: len = LEN_HALF;
      F3_WORD[1:0]: len = LEN_WORD;
      default:      len = LEN_WORD;
    endcase
    return len;
  endfunction

  always_comb begin
    dec           = '0;
    dec.cls       = CLS_RESULT;
    dec.alu_op    = ALU_NOP;
    dec.len       = LEN_WORD;
    dec.rs1       = instr_q[19:15];
    dec.rs2       = instr_q[24:20];
    dec.rd        = instr_q[11:7];
    case (opcode_e'(instr_q[6:0]))
      OPC_LUI: begin
        dec.imm       = imm_u;
        dec.res_ready = 1'b1;
        dec.res_value = imm_u;
      end
      OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.res_ready = 1'b1;
        dec.res_value = pc + imm_u;
      end
      OPC_JAL: begin
        dec.imm       = imm_j;
        dec.res_ready = 1'b1;
        dec.res_value = pc + XLEN'(4);  // link address
        dec.is_jump   = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.cls     = CLS_ALU;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        // addi has no sub form, bit 30 only matters for srai
        dec.alu_op  = alu_map(funct3, (funct3 == F3_SR) & instr_q[30]);
      end
      OPC_OP: begin
        dec.cls    = CLS_ALU;
        dec.alu_op = alu_map(funct3, instr_q[30]);
      end
      OPC_LOAD: begin
        dec.cls       = CLS_MEM;
        dec.imm       = imm_i;
        dec.is_signed = ~funct3[2];  // lbu / lhu clear it
        dec.len       = len_map(funct3);
      end
      OPC_STORE: begin
        dec.cls      = CLS_MEM;
        dec.imm      = imm_s;
        dec.is_store = 1'b1;
        dec.len      = len_map(funct3);
      end
      default: begin
        dec.res_ready = 1'b1;  // unknown word retires as a no-op result
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/operand_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_resolver
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic [REG_ID_W-1:0] reg_id,
  input  rf_resp_t            resp,
  input  cdb_t                cdb,
  output operand_t            opnd
);

  always_comb begin
    opnd.tag = resp.tag;
    if (reg_id == '0) begin
      opnd.value = '0;  // x0
      opnd.valid = 1'b1;
      opnd.tag   = '0;
    end else if (resp.valid) begin
      opnd.value = resp.value;
      opnd.valid = 1'b1;
    end else if (cdb.valid && (cdb.tag == resp.tag)) begin
      opnd.value = cdb.value;  // producer finishing this cycle
      opnd.valid = 1'b1;
    end else begin
      opnd.value = '0;
      opnd.valid = 1'b0;  // wait on tag in the station
    end
  end

endmodule

`default_nettype wire

/* hw/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_stage
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             issue_en,
  input  decoded_t         dec,
  input  operand_t         opnd1,
  input  operand_t         opnd2,
  input  logic [TAG_W-1:0] rob_index,
  output logic             rs_valid,
  output rs_pkt_t          rs_pkt,
  output logic             lsb_valid,
  output lsb_pkt_t         lsb_pkt,
  output logic             rob_valid,
  output rob_pkt_t         rob_pkt
);

  operand_t rs2_opnd;

  // op-imm carries the immediate as an always-ready second operand
  assign rs2_opnd = dec.use_imm ? '{value: dec.imm, valid: 1'b1, tag: '0} : opnd2;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rs_valid  <= 1'b0;
      lsb_valid <= 1'b0;
      rob_valid <= 1'b0;
    end else begin
      rs_valid  <= issue_en & (dec.cls == CLS_ALU);
      lsb_valid <= issue_en & (dec.cls == CLS_MEM);
      rob_valid <= issue_en;  // every instruction takes a rob entry
    end
  end

  always_ff @(posedge clk_in) begin
    if (issue_en) begin
      rs_pkt.op     <= dec.alu_op;
      rs_pkt.rs1    <= opnd1;
      rs_pkt.rs2    <= rs2_opnd;
      rs_pkt.rd_tag <= rob_index;

      lsb_pkt.is_store  <= dec.is_store;
      lsb_pkt.is_signed <= dec.is_signed;
      lsb_pkt.len       <= dec.len;
      lsb_pkt.addr      <= opnd1;  // base register
      lsb_pkt.value     <= opnd2;  // store data
      lsb_pkt.offset    <= dec.imm[11:0];
      lsb_pkt.rd_tag    <= rob_index;

      rob_pkt.kind  <= dec.is_store ? ROB_STORE : ROB_REG;
      // stores have nothing to wait for at commit
      rob_pkt.ready <= dec.res_ready | dec.is_store;
      rob_pkt.value <= dec.res_value;
      rob_pkt.rd    <= dec.rd;
    end
  end

  // one instruction goes to at most one execution buffer, always with its rob entry
  a_one_target: assert property (@(posedge clk_in) disable iff (rst_in)
    (rs_valid || lsb_valid) |-> (rob_valid && !(rs_valid && lsb_valid)));

endmodule

`default_nettype wire

/* hw/fetch_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_issue_top
  import isa_pkg::*;
  import issue_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic                clk_in,
  input  logic                rst_in,
  output logic                imem_req,
  output logic [XLEN-1:0]     imem_addr,
  input  logic                imem_ack,
  input  logic [XLEN-1:0]     imem_data,
  output logic [REG_ID_W-1:0] rf_rs1,
  output logic [REG_ID_W-1:0] rf_rs2,
  output logic [REG_ID_W-1:0] rf_rd,
  output logic                rf_rename,
  output logic [TAG_W-1:0]    rf_rename_tag,
  input  rf_resp_t            rf_resp1,
  input  rf_resp_t            rf_resp2,
  input  cdb_t                cdb,
  input  logic [TAG_W-1:0]    rob_index,
  input  logic                rs_full,
  input  logic                lsb_full,
  input  logic                rob_full,
  output logic                rs_valid,
  output rs_pkt_t             rs_pkt,
  output logic                lsb_valid,
  output lsb_pkt_t            lsb_pkt,
  output logic                rob_valid,
  output rob_pkt_t            rob_pkt
);

  logic            instr_load;
  logic            issue_en;
  logic            pc_advance;
  logic [XLEN-1:0] pc;
  decoded_t        dec;
  operand_t        opnd1, opnd2;

  fetch_ctrl u_fetch_ctrl (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .imem_ack   (imem_ack),
    .rs_full    (rs_full),
    .lsb_full   (lsb_full),
    .rob_full   (rob_full),
    .imem_req   (imem_req),
    .instr_load (instr_load),
    .issue_en   (issue_en),
    .pc_advance (pc_advance)
  );

  pc_counter #(.RESET_PC(RESET_PC)) u_pc_counter (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .pc_advance (pc_advance),
    .dec        (dec),
    .pc         (pc)
  );

  instr_decoder u_instr_decoder (
    .clk_in     (clk_in),
    .instr_load (instr_load),
    .imem_data  (imem_data),
    .pc         (pc),
    .dec        (dec)
  );

  operand_resolver u_opnd1 (
    .reg_id (dec.rs1),
    .resp   (rf_resp1),
    .cdb    (cdb),
    .opnd   (opnd1)
  );

  operand_resolver u_opnd2 (
    .reg_id (dec.rs2),
    .resp   (rf_resp2),
    .cdb    (cdb),
    .opnd   (opnd2)
  );

  issue_stage u_issue_stage (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .issue_en  (issue_en),
    .dec       (dec),
    .opnd1     (opnd1),
    .opnd2     (opnd2),
    .rob_index (rob_index),
    .rs_valid  (rs_valid),
    .rs_pkt    (rs_pkt),
    .lsb_valid (lsb_valid),
    .lsb_pkt   (lsb_pkt),
    .rob_valid (rob_valid),
    .rob_pkt   (rob_pkt)
  );

  assign imem_addr = pc;  // pc only moves after issue, so it is stable during req

  assign rf_rs1 = dec.rs1;
  assign rf_rs2 = dec.rs2;
  assign rf_rd  = dec.rd;

  // stores have no rd, x0 is never renamed
  assign rf_rename     = issue_en & ~dec.is_store & (dec.rd != '0);
  assign rf_rename_tag = rob_index;

endmodule

`default_nettype wire

/* sim/tb_fetch_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_issue
  import isa_pkg::*;
  import issue_pkg::*;
();

  localparam logic [31:0] RESET_PC = 32'h0000_1000;
  localparam int N_INSTR = 60;
  localparam int LIMIT   = N_INSTR * 24 + 40;  // handshake, memory delay and capped stalls

  typedef struct packed {
    instr_class_e cls;
    rs_pkt_t      rs;
    lsb_pkt_t     lsb;
    rob_pkt_t     rob;
    logic         rename;
    logic [31:0]  pc;
    logic [31:0]  next_pc;
  } expect_t;

  logic clk_in = 1'b0;
  logic rst_in;
  logic imem_req, imem_ack;
  logic [31:0] imem_addr, imem_data;
  logic [4:0] rf_rs1, rf_rs2, rf_rd;
  logic rf_rename;
  logic [TAG_W-1:0] rf_rename_tag, rob_index;
  rf_resp_t rf_resp1, rf_resp2;
  cdb_t cdb;
  logic rs_full, lsb_full, rob_full;
  logic rs_valid, lsb_valid, rob_valid;
  rs_pkt_t rs_pkt;
  lsb_pkt_t lsb_pkt;
  rob_pkt_t rob_pkt;

  rf_resp_t rf_q [32] = '{default: '0};
  logic [31:0] prog [256];
  expect_t exp_q [$];
  logic [31:0] exp_pc;
  int cycles, done_cnt, err_cnt, check_cnt, mem_wait, stall_run;
  logic busy, stall_q, rename_seen;

  fetch_issue_top #(.RESET_PC(RESET_PC)) u_dut (
    .clk_in(clk_in), .rst_in(rst_in),
    .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack), .imem_data(imem_data),
    .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_rd(rf_rd),
    .rf_rename(rf_rename), .rf_rename_tag(rf_rename_tag),
    .rf_resp1(rf_resp1), .rf_resp2(rf_resp2), .cdb(cdb), .rob_index(rob_index),
    .rs_full(rs_full), .lsb_full(lsb_full), .rob_full(rob_full),
    .rs_valid(rs_valid), .rs_pkt(rs_pkt), .lsb_valid(lsb_valid), .lsb_pkt(lsb_pkt),
    .rob_valid(rob_valid), .rob_pkt(rob_pkt)
  );

  always #2 clk_in = ~clk_in;

  // register file answers the ids on the port at once
  assign rf_resp1 = rf_q[rf_rs1];
  assign rf_resp2 = rf_q[rf_rs2];

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // value counts only when ready, the tag only while waiting
  task automatic check_opnd(input string what, input operand_t got, input operand_t exp);
    check({what, " valid"}, 64'(got.valid), 64'(exp.valid));
    if (exp.valid) check({what, " value"}, 64'(got.value), 64'(exp.value));
    else check({what, " tag"}, 64'(got.tag), 64'(exp.tag));
  endtask

  function automatic logic [31:0] gen_instr();
    logic [31:0] t, u;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3, lsel;
    logic [11:0] i12;
    logic [20:0] off;
    logic [31:0] w;
    t   = $urandom;
    u   = $urandom;
    rd  = {2'b00, t[2:0]};  // x0..x7 keeps renames and tag hits frequent
    rs1 = {2'b00, t[5:3]};
    rs2 = {2'b00, t[8:6]};
    f3  = t[11:9];
    i12 = t[23:12];
    case ($urandom % 7)
      0: w = {u[31:12], rd, OPC_LUI};
      1: w = {u[31:12], rd, OPC_AUIPC};
      2: begin
        off = 21'(1 + ($urandom % 15)) << 2;
        if (t[27]) off = -off;
        w = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
      end
      3: w = {i12, rs1, f3, rd, OPC_OP_IMM};
      4: w = {1'b0, t[28], 5'b0, rs2, rs1, f3, rd, OPC_OP};
      5: begin
        lsel = 3'(u % 5);
        f3   = (lsel < 3'd3) ? lsel : lsel + 3'd1;  // lb lh lw lbu lhu
        w = {i12, rs1, f3, rd, OPC_LOAD};
      end
      default: w = {i12[11:5], rs2, rs1, 3'(u % 3), i12[4:0], OPC_STORE};
    endcase
    return w;
  endfunction

  function automatic operand_t resolve(input logic [4:0] id, input rf_resp_t r, input cdb_t c);
    operand_t o;
    o.tag = r.tag;
    o.value = '0;
    o.valid = 1'b0;
    if (id == 5'd0) begin
      o.valid = 1'b1;
      o.tag = '0;
    end else if (r.valid) begin
      o.valid = 1'b1;
      o.value = r.value;
    end else if (c.valid && c.tag == r.tag) begin
      o.valid = 1'b1;
      o.value = c.value;
    end
    return o;
  endfunction

  function automatic alu_op_e op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_LT;
      3'b011:  return ALU_LTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic lsb_len_e len_of(input logic [2:0] f3);
    case (f3[1:0])
      2'b00:   return LEN_BYTE;
      2'b01:   return LEN_HALF;
      default: return LEN_WORD;
    endcase
  endfunction

  function automatic expect_t ref_model(input logic [31:0] ins, input logic [31:0] pc,
                                        input rf_resp_t rf_st [32], input cdb_t c,
                                        input logic [TAG_W-1:0] tail);
    expect_t e;
    logic [2:0] f3;
    logic [31:0] ii, is, iu, ij;
    operand_t o1, o2;
    f3 = ins[14:12];
    ii = {{20{ins[31]}}, ins[31:20]};
    is = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    iu = {ins[31:12], 12'b0};
    ij = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    o1 = resolve(ins[19:15], rf_st[ins[19:15]], c);
    o2 = resolve(ins[24:20], rf_st[ins[24:20]], c);
    e = '0;
    e.cls = CLS_RESULT;
    e.pc = pc;
    e.next_pc = pc + 32'd4;
    e.rob.kind = ROB_REG;
    e.rob.rd = ins[11:7];
    e.rs.rd_tag = tail;
    e.lsb.rd_tag = tail;
    e.lsb.addr = o1;
    e.lsb.len = len_of(f3);
    case (opcode_e'(ins[6:0]))
      OPC_LUI: begin
        e.rob.ready = 1'b1;
        e.rob.value = iu;
      end
      OPC_AUIPC: begin
        e.rob.ready = 1'b1;
        e.rob.value = pc + iu;
      end
      OPC_JAL: begin
        e.rob.ready = 1'b1;
        e.rob.value = pc + 32'd4;
        e.next_pc = pc + ij;
      end
      OPC_OP_IMM: begin
        e.cls = CLS_ALU;
        e.rs.op = op_of(f3, (f3 == 3'b101) & ins[30]);
        e.rs.rs1 = o1;
        e.rs.rs2 = '{value: ii, valid: 1'b1, tag: '0};
      end
      OPC_OP: begin
        e.cls = CLS_ALU;
        e.rs.op = op_of(f3, ins[30]);
        e.rs.rs1 = o1;
        e.rs.rs2 = o2;
      end
      OPC_LOAD: begin
        e.cls = CLS_MEM;
        e.lsb.is_signed = ~f3[2];
        e.lsb.offset = ii[11:0];
      end
      default: begin  // store
        e.cls = CLS_MEM;
        e.lsb.is_store = 1'b1;
        e.lsb.value = o2;
        e.lsb.offset = is[11:0];
        e.rob.kind = ROB_STORE;
        e.rob.ready = 1'b1;
      end
    endcase
    e.rename = (opcode_e'(ins[6:0]) != OPC_STORE) && (ins[11:7] != 5'd0);
    return e;
  endfunction

  // memory: ack after 1..4 cycles, expected packets taken when the word goes out
  always @(posedge clk_in) begin : mem_model
    expect_t e;
    if (rst_in) begin
      imem_ack <= 1'b0;
      busy = 1'b0;
      exp_pc = RESET_PC;
    end else if (imem_ack) begin
      if (!imem_req) imem_ack <= 1'b0;
    end else if (busy) begin
      if (mem_wait > 1) begin
        mem_wait--;
      end else begin
        busy = 1'b0;
        check("imem_addr", 64'(imem_addr), 64'(exp_pc));
        imem_ack  <= 1'b1;
        imem_data <= prog[imem_addr[9:2]];
        e = ref_model(prog[imem_addr[9:2]], imem_addr, rf_q, cdb, rob_index);
        exp_q.push_back(e);
        exp_pc = e.next_pc;
      end
    end else if (imem_req) begin
      busy = 1'b1;
      mem_wait = 1 + int'($urandom % 4);
    end
  end

  // register file, rob tail and broadcast bus
  always @(posedge clk_in) begin : env_model
    logic [31:0] t;
    logic [4:0]  pick;
    if (rst_in) begin
      cdb <= '0;
      rob_index <= '0;
      for (int i = 1; i < 32; i++) begin
        t = $urandom;
        rf_q[i] <= '{value: $urandom, valid: t[0] | t[1], tag: t[7:4]};
      end
    end else begin
      if (rf_rename) begin
        rf_q[rf_rd].valid <= 1'b0;
        rf_q[rf_rd].tag   <= rf_rename_tag;
      end
      if (rob_valid) begin
        rob_index <= rob_index + 4'd1;
        for (int i = 1; i < 32; i++) begin
          if (cdb.valid && !rf_q[i].valid && rf_q[i].tag == cdb.tag) begin
            rf_q[i].valid <= 1'b1;
            rf_q[i].value <= cdb.value;
          end
        end
        t = $urandom;
        pick = 5'(1 + ($urandom % 7));
        cdb <= '{valid: t[0] | t[1], tag: t[2] ? rf_q[pick].tag : t[6:3], value: $urandom};
      end
    end
  end

  // random back-pressure, never longer than six cycles in a row
  always @(posedge clk_in) begin : full_driver
    logic [31:0] t;
    t = $urandom;
    if (rst_in || stall_run >= 6) begin
      rs_full <= 1'b0;
      lsb_full <= 1'b0;
      rob_full <= 1'b0;
      stall_run = 0;
    end else begin
      rs_full  <= (t[1:0] == 2'b00);
      lsb_full <= (t[3:2] == 2'b00);
      rob_full <= (t[5:4] == 2'b00);
      if (t[1:0] == 2'b00 || t[3:2] == 2'b00 || t[5:4] == 2'b00) stall_run++;
      else stall_run = 0;
    end
  end

  always @(posedge clk_in) begin : compare
    expect_t e;
    int errs_before;
    if (rst_in) begin
      stall_q = 1'b0;
      rename_seen = 1'b0;
    end else begin
      if (rob_valid && stall_q) begin
        err_cnt++;
        $display("issue pulse at %0t follows a cycle with a full input high", $time);
      end
      if (rob_valid && exp_q.size() == 0) begin
        err_cnt++;
        $display("rob_valid at %0t with no fetched instruction pending", $time);
      end else if (rob_valid) begin
        e = exp_q.pop_front();
        errs_before = err_cnt;
        check("rob kind", 64'(rob_pkt.kind), 64'(e.rob.kind));
        check("rob ready", 64'(rob_pkt.ready), 64'(e.rob.ready));
        if (!e.lsb.is_store) check("rob rd", 64'(rob_pkt.rd), 64'(e.rob.rd));
        if (e.cls == CLS_RESULT) check("rob value", 64'(rob_pkt.value), 64'(e.rob.value));
        check("rs_valid", 64'(rs_valid), 64'(e.cls == CLS_ALU));
        check("lsb_valid", 64'(lsb_valid), 64'(e.cls == CLS_MEM));
        if (e.cls == CLS_ALU) begin
          check("rs op", 64'(rs_pkt.op), 64'(e.rs.op));
          check_opnd("rs rs1", rs_pkt.rs1, e.rs.rs1);
          check_opnd("rs rs2", rs_pkt.rs2, e.rs.rs2);
          check("rs rd_tag", 64'(rs_pkt.rd_tag), 64'(e.rs.rd_tag));
        end
        if (e.cls == CLS_MEM) begin
          check("lsb store", 64'(lsb_pkt.is_store), 64'(e.lsb.is_store));
          check("lsb signed", 64'(lsb_pkt.is_signed), 64'(e.lsb.is_signed));
          check("lsb len", 64'(lsb_pkt.len), 64'(e.lsb.len));
          check("lsb offset", 64'(lsb_pkt.offset), 64'(e.lsb.offset));
          check_opnd("lsb addr", lsb_pkt.addr, e.lsb.addr);
          if (e.lsb.is_store) check_opnd("lsb value", lsb_pkt.value, e.lsb.value);
          check("lsb rd_tag", 64'(lsb_pkt.rd_tag), 64'(e.lsb.rd_tag));
        end
        check("rename pulse", 64'(rename_seen), 64'(e.rename));
        rename_seen = 1'b0;
        $display("instr %0d pc %h class %0d: %s", done_cnt, e.pc, e.cls,
                 (err_cnt == errs_before) ? "ok" : "errors");
        done_cnt++;
      end
      if (rf_rename) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("rename pulse at %0t with no fetched instruction pending", $time);
        end else begin
          // the word being issued is still at the head of the queue
          check("rename rd", 64'(rf_rd), 64'(exp_q[0].rob.rd));
          check("rename tag", 64'(rf_rename_tag), 64'(exp_q[0].rs.rd_tag));
        end
        rename_seen = 1'b1;
      end
      stall_q = rs_full | lsb_full | rob_full;
    end
  end

  always @(posedge clk_in) cycles++;

  initial begin
    void'($urandom(32'h57b4));
    rst_in = 1'b1;
    imem_ack = 1'b0;
    imem_data = '0;
    cdb = '0;
    rob_index = '0;
    rs_full = 1'b0;
    lsb_full = 1'b0;
    rob_full = 1'b0;
    for (int i = 0; i < 256; i++) prog[i] = gen_instr();
    repeat (10) @(posedge clk_in);
    rst_in <= 1'b0;
    while (done_cnt < N_INSTR && cycles < LIMIT) @(posedge clk_in);
    if (done_cnt < N_INSTR) begin
      $display("timeout after %0d cycles with %0d of %0d instructions issued",
               cycles, done_cnt, N_INSTR);
      $display("Testbench failed");
    end else begin
      $display("instructions %0d, checks %0d, errors %0d", done_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) $display("Testbench passed");
      else $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/fetch_ctrl.sv
hw/pc_counter.sv
hw/instr_decoder.sv
hw/operand_resolver.sv
hw/issue_stage.sv
hw/fetch_issue_top.sv
sim/tb_fetch_issue.sv

/* run.sh */
#!/bin/sh
# compile and run the fetch/issue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_fetch_issue \
  --Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
